/* Bender.yml */
package:
  name: oric_tape_audio

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/oric_pkg.sv
      - tape/tape_cache.sv
      - tape/tape_player.sv
      - audio/audio_mixer.sv
      - audio/sigma_delta_dac.sv
      - design/oric_tape_audio_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_oric_tape_audio.sv

/* audio/audio_mixer.sv */
//==================================================
// voice mixing by stereo mode plus tape sound
// output registered one clock after the inputs
// sums wrap modulo 2^16, no clipping
//==================================================
`timescale 1ns/1ns
`include "oric_defines.svh"

module audio_mixer (
	input  logic clk_sys,
	input  logic reset,
	input  oric_pkg::psg_voices_t voices_i,
	input  oric_pkg::stereo_mode_e stereo_i,
	input  oric_pkg::tape_volume_e volume_i,
	input  logic tape_bit_i,
	output oric_pkg::audio_sample_t sample_o
);

	localparam int SUM_W = `ORIC_VOICE_W + 1;

	logic [SUM_W-1:0] sum_ab;
	logic [SUM_W-1:0] sum_ac;
	logic [SUM_W-1:0] sum_bc;
	logic [`ORIC_SAMPLE_W-1:0] mix_l;
	logic [`ORIC_SAMPLE_W-1:0] mix_r;
	logic [`ORIC_SAMPLE_W-1:0] tape_snd;

	// pair sums keep the carry
	assign sum_ab = {1'b0, voices_i.a} + {1'b0, voices_i.b};
	assign sum_ac = {1'b0, voices_i.a} + {1'b0, voices_i.c};
	assign sum_bc = {1'b0, voices_i.b} + {1'b0, voices_i.c};

	always_comb begin
		case (stereo_i)
			oric_pkg::MONO: begin
				mix_l = {voices_i.mix, 2'b00};
				mix_r = {voices_i.mix, 2'b00};
			end
			oric_pkg::ABC: begin
				mix_l = {sum_ab, 3'b000};
				mix_r = {sum_bc, 3'b000};
			end
			// ACB and the spare code
			default: begin
				mix_l = {sum_ac, 3'b000};
				mix_r = {sum_bc, 3'b000};
			end
		endcase
	end

	// tape click level
	always_comb begin
		case (volume_i)
			oric_pkg::MUTE: tape_snd = '0;
			oric_pkg::LOW:  tape_snd = {9'd0, tape_bit_i, 6'd0};
			default:        tape_snd = {8'd0, tape_bit_i, 7'd0};
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sample_o <= '0;
		end else begin
			sample_o.left <= mix_l + tape_snd;
			sample_o.right <= mix_r + tape_snd;
		end
	end

endmodule

/* audio/sigma_delta_dac.sv */
//==================================================
// first-order 1-bit DAC for one channel
// over 2^16 clocks the count of ones equals the sample
//==================================================
`timescale 1ns/1ns
`include "oric_defines.svh"

module sigma_delta_dac (
	input  logic clk_sys,
	input  logic reset,
	input  logic [`ORIC_SAMPLE_W-1:0] sample_i,
	output logic dac_o
);

	logic [`ORIC_SAMPLE_W:0] acc;

	// carry out of the low bits is the pulse
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[`ORIC_SAMPLE_W-1:0]} + {1'b0, sample_i};
		end
	end

	assign dac_o = acc[`ORIC_SAMPLE_W];

endmodule

/* common/oric_defines.svh */
//==================================================
// widths, tape depth and tape bit period
// one tape size and one bit rate per build
// the tape address width and the depth must agree
//==================================================
`ifndef ORIC_DEFINES_SVH
`define ORIC_DEFINES_SVH

// tape cache geometry
`define ORIC_TAPE_AW 16
`define ORIC_TAPE_DEPTH 65536
`define ORIC_BYTE_W 8

// sound generator outputs
`define ORIC_VOICE_W 12
`define ORIC_PSG_MIX_W 14

// mixed sample fed to the DACs
`define ORIC_SAMPLE_W 16

// clocks per serial tape bit
`define ORIC_TAPE_BIT_CYCLES 8

`endif

/* common/oric_pkg.sv */
//==================================================
// shared types of the tape and sound path
// wishbone classic only, no stall and no error
// stereo code 3 acts as ACB, volume code 3 as HIGH
//==================================================
`include "oric_defines.svh"

package oric_pkg;

	// wishbone classic request from the host
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`ORIC_TAPE_AW-1:0] adr;
		logic [`ORIC_BYTE_W-1:0] dat;
	} wb_req_t;

	// response, read data valid with ack
	typedef struct packed {
		logic ack;
		logic [`ORIC_BYTE_W-1:0] dat;
	} wb_rsp_t;

	// three voices plus the chip's own mono mix
	typedef struct packed {
		logic [`ORIC_VOICE_W-1:0] a;
		logic [`ORIC_VOICE_W-1:0] b;
		logic [`ORIC_VOICE_W-1:0] c;
		logic [`ORIC_PSG_MIX_W-1:0] mix;
	} psg_voices_t;

	typedef enum logic [1:0] {
		MONO = 2'd0,
		ABC  = 2'd1,
		ACB  = 2'd2
	} stereo_mode_e;

	typedef enum logic [1:0] {
		MUTE = 2'd0,
		LOW  = 2'd1,
		HIGH = 2'd2
	} tape_volume_e;

	// cassette controls from the machine and the menu
	typedef struct packed {
		logic motor;
		logic use_adc;
		logic rewind;
		tape_volume_e volume;
	} tape_ctrl_t;

	typedef struct packed {
		logic [`ORIC_SAMPLE_W-1:0] left;
		logic [`ORIC_SAMPLE_W-1:0] right;
	} audio_sample_t;

endpackage

/* design/oric_tape_audio_top.sv */
//==================================================
// cassette and sound path of the home computer core
// tape_adc_i is asynchronous, two flops to clk_sys
// the tape cache is written only during load_active_i
// tape_bit_o is combinational from the source select
//==================================================
`timescale 1ns/1ns
`include "oric_defines.svh"

module oric_tape_audio_top (
	input  logic clk_sys,
	input  logic reset,
	input  oric_pkg::wb_req_t wb_req_i,
	output oric_pkg::wb_rsp_t wb_rsp_o,
	input  logic load_active_i,
	input  oric_pkg::tape_ctrl_t tape_ctrl_i,
	input  logic tape_adc_i,
	input  oric_pkg::psg_voices_t voices_i,
	input  oric_pkg::stereo_mode_e stereo_i,
	output logic tape_bit_o,
	output logic playing_o,
	output oric_pkg::audio_sample_t sample_o,
	output logic audio_l_o,
	output logic audio_r_o
);

	logic [`ORIC_TAPE_AW-1:0] play_addr;
	logic [`ORIC_BYTE_W-1:0] play_data;
	logic [`ORIC_TAPE_AW-1:0] tape_end;
	logic tape_loaded;
	logic player_en;
	logic player_rewind;
	logic player_bit;
	logic [1:0] adc_sync;

	//==================================================
	// tape source
	//==================================================
	assign player_en = tape_ctrl_i.motor && tape_loaded && !tape_ctrl_i.use_adc &&
		!load_active_i && !tape_ctrl_i.rewind;
	// a download always restarts from byte 0
	assign player_rewind = tape_ctrl_i.rewind || load_active_i;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			adc_sync <= 2'b00;
		end else begin
			adc_sync <= {adc_sync[0], tape_adc_i};
		end
	end

	assign tape_bit_o = tape_ctrl_i.use_adc ? adc_sync[1] : player_bit;

	tape_cache tape_cache_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.wb_req_i      (wb_req_i),
		.wb_rsp_o      (wb_rsp_o),
		.load_active_i (load_active_i),
		.play_addr_i   (play_addr),
		.play_data_o   (play_data),
		.tape_end_o    (tape_end),
		.loaded_o      (tape_loaded)
	);

	tape_player tape_player_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.enable_i    (player_en),
		.rewind_i    (player_rewind),
		.tape_end_i  (tape_end),
		.play_addr_o (play_addr),
		.play_data_i (play_data),
		.tape_bit_o  (player_bit),
		.playing_o   (playing_o)
	);

	//==================================================
	// sound
	//==================================================
	audio_mixer audio_mixer_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.voices_i   (voices_i),
		.stereo_i   (stereo_i),
		.volume_i   (tape_ctrl_i.volume),
		.tape_bit_i (tape_bit_o),
		.sample_o   (sample_o)
	);

	sigma_delta_dac dac_l_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.sample_i (sample_o.left),
		.dac_o    (audio_l_o)
	);

	sigma_delta_dac dac_r_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.sample_i (sample_o.right),
		.dac_o    (audio_r_o)
	);

endmodule

/* oric_tape_audio.f */
+incdir+common
common/oric_pkg.sv
tape/tape_cache.sv
tape/tape_player.sv
audio/audio_mixer.sv
audio/sigma_delta_dac.sv
design/oric_tape_audio_top.sv
tb/tb_oric_tape_audio.sv

/* tape/tape_cache.sv */
//==================================================
// tape image memory behind a wishbone classic port
// ack one clock after the access, read data with ack
// host owns the memory only while load_active_i is high
// the player read port has one cycle of latency
// loaded flag clears on reset only
//==================================================
`timescale 1ns/1ns
`include "oric_defines.svh"

module tape_cache (
	input  logic clk_sys,
	input  logic reset,
	input  oric_pkg::wb_req_t wb_req_i,
	output oric_pkg::wb_rsp_t wb_rsp_o,
	input  logic load_active_i,
	input  logic [`ORIC_TAPE_AW-1:0] play_addr_i,
	output logic [`ORIC_BYTE_W-1:0] play_data_o,
	output logic [`ORIC_TAPE_AW-1:0] tape_end_o,
	output logic loaded_o
);

	logic [`ORIC_BYTE_W-1:0] mem [0:`ORIC_TAPE_DEPTH-1];
	logic [`ORIC_BYTE_W-1:0] rd_q;
	logic [`ORIC_TAPE_AW-1:0] mem_addr;
	logic [`ORIC_TAPE_AW-1:0] tape_end_q;
	logic ack_q;
	logic load_q;
	logic loaded_q;
	logic access;
	logic wr_en;

	// new access only while ack is low
	assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
	assign wr_en = access && wb_req_i.we && load_active_i;

	// host address during a session, player address otherwise
	assign mem_addr = load_active_i ? wb_req_i.adr : play_addr_i;

	//==================================================
	// memory array
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[mem_addr] <= wb_req_i.dat;
		end
		rd_q <= mem[mem_addr];
	end

	//==================================================
	// bus handshake and session tracking
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_q <= 1'b0;
			load_q <= 1'b0;
			loaded_q <= 1'b0;
			tape_end_q <= '0;
		end else begin
			ack_q <= access;
			load_q <= load_active_i;
			// first cycle of a download session
			if (load_active_i && !load_q) begin
				loaded_q <= 1'b1;
			end
			// last written address is the tape end
			if (wr_en) begin
				tape_end_q <= wb_req_i.adr;
			end
		end
	end

	assign wb_rsp_o.ack = ack_q;
	assign wb_rsp_o.dat = rd_q;
	assign play_data_o = rd_q;
	assign tape_end_o = tape_end_q;
	assign loaded_o = loaded_q;

endmodule

/* tape/tape_player.sv */
//==================================================
// serial tape bit from cached bytes, msb first
// first bit appears two clocks after enable rises
// pause holds position and output, rewind restarts
// byte 0 to tape_end_i inclusive, then output 0
//==================================================
`timescale 1ns/1ns
`include "oric_defines.svh"

module tape_player (
	input  logic clk_sys,
	input  logic reset,
	input  logic enable_i,
	input  logic rewind_i,
	input  logic [`ORIC_TAPE_AW-1:0] tape_end_i,
	output logic [`ORIC_TAPE_AW-1:0] play_addr_o,
	input  logic [`ORIC_BYTE_W-1:0] play_data_i,
	output logic tape_bit_o,
	output logic playing_o
);

	localparam int CNT_W = $clog2(`ORIC_TAPE_BIT_CYCLES);
	localparam int IDX_W = $clog2(`ORIC_BYTE_W);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`ORIC_TAPE_BIT_CYCLES - 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`ORIC_BYTE_W - 1);

	// prime waits for the cache read latency
	typedef enum logic [1:0] {
		ST_PRIME,
		ST_LOAD,
		ST_SHIFT,
		ST_DONE
	} play_state_e;

	play_state_e state;
	logic [`ORIC_TAPE_AW-1:0] byte_addr;
	logic [CNT_W-1:0] bit_cnt;
	logic [IDX_W-1:0] bit_idx;
	logic [`ORIC_BYTE_W-1:0] shreg;
	logic last_byte;
	logic bit_end;
	logic byte_end;
	logic load_byte;
	logic shift_bit;

	assign bit_end = (state == ST_SHIFT) && (bit_cnt == LAST_CNT);
	assign byte_end = bit_end && (bit_idx == LAST_IDX);
	assign load_byte = (state == ST_LOAD) || (byte_end && !last_byte);
	assign shift_bit = bit_end && !byte_end;

	//==================================================
	// position and output control
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (reset || rewind_i) begin
			state <= ST_PRIME;
			byte_addr <= '0;
			bit_cnt <= '0;
			bit_idx <= '0;
			last_byte <= 1'b0;
			tape_bit_o <= 1'b0;
			playing_o <= 1'b0;
		end else if (enable_i) begin
			if (state == ST_PRIME) begin
				state <= ST_LOAD;
			end
			if (load_byte) begin
				state <= ST_SHIFT;
				byte_addr <= byte_addr + 1'b1;
				last_byte <= (byte_addr == tape_end_i);
				bit_cnt <= '0;
				bit_idx <= '0;
			end else if (state == ST_SHIFT) begin
				bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
				if (shift_bit) begin
					bit_idx <= bit_idx + 1'b1;
				end
				// last bit of the tape-end byte done
				if (byte_end) begin
					state <= ST_DONE;
				end
			end
			tape_bit_o <= (state == ST_SHIFT) ? shreg[`ORIC_BYTE_W-1] : 1'b0;
			playing_o <= (state == ST_SHIFT);
		end
	end

	// shift register, payload only
	always_ff @(posedge clk_sys) begin
		if (!reset && !rewind_i && enable_i) begin
			if (load_byte) begin
				shreg <= play_data_i;
			end else if (shift_bit) begin
				shreg <= {shreg[`ORIC_BYTE_W-2:0], 1'b0};
			end
		end
	end

	assign play_addr_o = byte_addr;

endmodule

/* tb/oric_tape_audio_vectors.txt */
// tape: byte count, then the bytes; mixer and DAC: case count, then one case per line
// case columns: stereo volume tape_bit voice_a voice_b voice_c mix expect_left expect_right
06
A5 3C 00 FF 81 5A
// mixer cases
0A
0 0 0 07B 1C8 315 1234 48D0 48D0
0 1 1 000 000 000 3FFF 003C 003C
1 0 1 100 200 300 0000 1800 2800
1 2 1 FFF FFF 001 0AAA 0070 8080
2 1 1 010 020 030 1111 0240 02C0
2 2 0 ABC 123 456 0000 7890 2BC8
3 3 1 800 001 7FF 2000 8078 4080
0 3 1 FFF FFF FFF 0001 0084 0084
1 1 0 555 AAA 333 0000 7FF8 6EE8
3 0 1 001 002 003 0000 0020 0028
// DAC cases, tape sound muted
02
1 0 0 123 045 678 0000 0B40 35E8
0 0 0 000 000 000 3FFF FFFC FFFC

/* tb/tb_oric_tape_audio.sv */
//==================================================
// testbench for the cassette and sound path
// reads tb/oric_tape_audio_vectors.txt, run from the project root
// stops at the first mismatch
//==================================================
`timescale 1ns/1ns
`include "oric_defines.svh"

module tb_oric_tape_audio;

	localparam int BIT = `ORIC_TAPE_BIT_CYCLES;
	// enabled edge count at which tape bit 0 shows
	localparam int FIRST_BIT_N = 3;
	localparam int REC_W = 9;
	localparam int N_RANDOM = 16;
	localparam int DAC_WINDOW = 65536;

	logic clk_sys;
	logic reset;
	oric_pkg::wb_req_t wb_req;
	oric_pkg::wb_rsp_t wb_rsp;
	logic load_active;
	oric_pkg::tape_ctrl_t tape_ctrl;
	logic tape_adc;
	oric_pkg::psg_voices_t voices;
	oric_pkg::stereo_mode_e stereo;
	logic tape_bit;
	logic playing;
	oric_pkg::audio_sample_t sample;
	logic audio_l;
	logic audio_r;

	logic [31:0] vec [0:255];
	logic [7:0] tape_bytes [0:63];
	int n_tape;
	int play_n;
	int watchdog_cycles;
	logic loaded_model;

	oric_tape_audio_top oric_tape_audio_top_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.wb_req_i      (wb_req),
		.wb_rsp_o      (wb_rsp),
		.load_active_i (load_active),
		.tape_ctrl_i   (tape_ctrl),
		.tape_adc_i    (tape_adc),
		.voices_i      (voices),
		.stereo_i      (stereo),
		.tape_bit_o    (tape_bit),
		.playing_o     (playing),
		.sample_o      (sample),
		.audio_l_o     (audio_l),
		.audio_r_o     (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	//==================================================
	// checks
	//==================================================
	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic check_rsp(input string name, input oric_pkg::wb_rsp_t exp,
		input oric_pkg::wb_rsp_t act);
		if (act !== exp)
			fail_now($sformatf("** Error [%s] expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_sample(input string name, input oric_pkg::audio_sample_t exp,
		input oric_pkg::audio_sample_t act);
		if (act !== exp)
			fail_now($sformatf("** Error [%s] expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_now($sformatf("** Error [%s] expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			fail_now($sformatf("** Error [%s] expected %0d, actual %0d", name, exp, act));
	endtask

	//==================================================
	// reference model of the player
	//==================================================
	function automatic logic expected_bit(input int n);
		int k;
		logic [7:0] b;
		if (n < FIRST_BIT_N)
			return 1'b0;
		k = (n - FIRST_BIT_N) / BIT;
		if (k >= 8 * n_tape)
			return 1'b0;
		b = tape_bytes[k / 8];
		// msb first
		return b[7 - (k % 8)];
	endfunction

	function automatic logic expected_playing(input int n);
		return (n >= FIRST_BIT_N) && ((n - FIRST_BIT_N) / BIT < 8 * n_tape);
	endfunction

	// one clock, tracking how many enabled edges the player has seen
	task automatic tick();
		logic en;
		en = tape_ctrl.motor && loaded_model && !tape_ctrl.use_adc && !load_active &&
			!tape_ctrl.rewind;
		@(posedge clk_sys);
		if (reset || tape_ctrl.rewind || load_active)
			play_n = 0;
		else if (en)
			play_n++;
		@(negedge clk_sys);
	endtask

	task automatic player_step(input logic motor, input int count);
		for (int i = 0; i < count; i++) begin
			tape_ctrl.motor = motor;
			tick();
			check_bit($sformatf("tape bit, edge %0d", play_n), expected_bit(play_n), tape_bit);
			check_bit($sformatf("playing, edge %0d", play_n), expected_playing(play_n), playing);
		end
	endtask

	task automatic wb_access(input logic we, input int adr, input logic [7:0] dat);
		oric_pkg::wb_rsp_t exp;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr[`ORIC_TAPE_AW-1:0];
		wb_req.dat = we ? dat : 8'h00;
		tick();
		exp.ack = 1'b1;
		exp.dat = dat;
		if (we)
			check_bit($sformatf("write ack, address %0d", adr), 1'b1, wb_rsp.ack);
		else
			check_rsp($sformatf("read, address %0d", adr), exp, wb_rsp);
		wb_req = '0;
		tick();
		check_bit($sformatf("ack drop, address %0d", adr), 1'b0, wb_rsp.ack);
	endtask

	//==================================================
	// reference model of the mixer
	//==================================================
	function automatic oric_pkg::audio_sample_t mix_rule(input logic [1:0] mode,
		input logic [1:0] vol, input logic tbit, input logic [11:0] a, input logic [11:0] b,
		input logic [11:0] c, input logic [13:0] mix);
		oric_pkg::audio_sample_t s;
		int tape_snd;
		int l;
		int r;
		tape_snd = (vol == 2'd0) ? 0 : (vol == 2'd1) ? 64 * tbit : 128 * tbit;
		if (mode == 2'd0) begin
			l = mix * 4;
			r = mix * 4;
		end else if (mode == 2'd1) begin
			l = (a + b) * 8;
			r = (b + c) * 8;
		end else begin
			l = (a + c) * 8;
			r = (b + c) * 8;
		end
		s.left = 16'(l + tape_snd);
		s.right = 16'(r + tape_snd);
		return s;
	endfunction

	// tape bit goes through the ADC path, so it settles two clocks ahead
	task automatic run_mix_case(input string name, input logic [1:0] mode, input logic [1:0] vol,
		input logic tbit, input logic [11:0] a, input logic [11:0] b, input logic [11:0] c,
		input logic [13:0] mix, input oric_pkg::audio_sample_t exp);
		tape_adc = tbit;
		tick();
		tick();
		stereo = oric_pkg::stereo_mode_e'(mode);
		tape_ctrl.volume = oric_pkg::tape_volume_e'(vol);
		voices.a = a;
		voices.b = b;
		voices.c = c;
		voices.mix = mix;
		tick();
		check_sample(name, exp, sample);
	endtask

	task automatic count_dac_ones(input string name, input oric_pkg::audio_sample_t exp);
		int ones_l;
		int ones_r;
		ones_l = 0;
		ones_r = 0;
		for (int i = 0; i < DAC_WINDOW; i++) begin
			tick();
			ones_l += (audio_l === 1'b1);
			ones_r += (audio_r === 1'b1);
		end
		check_count({name, " left ones"}, int'(exp.left), ones_l);
		check_count({name, " right ones"}, int'(exp.right), ones_r);
	endtask

	//==================================================
	// test sequence
	//==================================================
	initial begin
		int r;
		int n_mix;
		int n_dac;
		logic adc_prev;
		logic [1:0] m;
		logic [1:0] v;
		oric_pkg::audio_sample_t exp;

		void'($urandom(32'h7a5e_f9b1));
		reset = 1'b1;
		wb_req = '0;
		load_active = 1'b0;
		tape_ctrl = '0;
		tape_adc = 1'b0;
		voices = '0;
		stereo = oric_pkg::MONO;
		play_n = 0;
		loaded_model = 1'b0;
		watchdog_cycles = 0;

		$readmemh("tb/oric_tape_audio_vectors.txt", vec);
		n_tape = vec[0];
		if ($isunknown(vec[0]) || n_tape < 1 || n_tape > 64)
			fail_now("the vector file is missing or its tape byte count is out of range");
		for (int i = 0; i < n_tape; i++) begin
			tape_bytes[i] = vec[1 + i][7:0];
		end
		n_mix = vec[n_tape + 1];
		n_dac = vec[n_tape + 2 + REC_W * n_mix];
		if ($isunknown(vec[n_tape + 1]) || $isunknown(vec[n_tape + 2 + REC_W * n_mix]))
			fail_now("the vector file is cut short, a case count is missing");
		watchdog_cycles = 2 * (1000 + 8 * n_tape + 4 * n_tape * 8 * BIT +
			8 * (n_mix + N_RANDOM) + n_dac * (DAC_WINDOW + 8));

		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// state right after reset
		check_bit("reset ack", 1'b0, wb_rsp.ack);
		check_bit("reset playing", 1'b0, playing);
		check_bit("reset tape bit", 1'b0, tape_bit);
		check_sample("reset sample", '0, sample);
		check_bit("reset dac left", 1'b0, audio_l);
		check_bit("reset dac right", 1'b0, audio_r);
		// motor on with nothing loaded
		player_step(1'b1, 40);
		tape_ctrl.motor = 1'b0;

		// download, then read back in a second session
		load_active = 1'b1;
		loaded_model = 1'b1;
		for (int i = 0; i < n_tape; i++)
			wb_access(1'b1, i, tape_bytes[i]);
		load_active = 1'b0;
		tick();
		load_active = 1'b1;
		for (int i = 0; i < n_tape; i++)
			wb_access(1'b0, i, tape_bytes[i]);
		load_active = 1'b0;
		tick();

		// playback with a pause in the middle of a bit
		player_step(1'b1, 100);
		player_step(1'b0, 37);
		player_step(1'b1, FIRST_BIT_N + 8 * BIT * n_tape - 100 + 20);

		// rewind once the tape has ended, then again while a one shows
		tape_ctrl.rewind = 1'b1;
		tick();
		tape_ctrl.rewind = 1'b0;
		while (tape_bit !== 1'b1 && play_n < FIRST_BIT_N + 8 * BIT * n_tape)
			player_step(1'b1, 1);
		tape_ctrl.rewind = 1'b1;
		tick();
		tape_ctrl.rewind = 1'b0;
		check_bit("tape bit after rewind", 1'b0, tape_bit);
		check_bit("playing after rewind", 1'b0, playing);
		player_step(1'b1, FIRST_BIT_N + 2 * 8 * BIT);

		// analog source, player frozen meanwhile
		tape_ctrl.use_adc = 1'b1;
		adc_prev = tape_adc;
		for (int i = 0; i < 40; i++) begin
			tape_adc = expected_bit(FIRST_BIT_N + i * 3);
			tick();
			check_bit($sformatf("adc follow %0d", i), adc_prev, tape_bit);
			check_bit($sformatf("adc playing %0d", i), expected_playing(play_n), playing);
			adc_prev = tape_adc;
		end
		tape_ctrl.use_adc = 1'b0;
		player_step(1'b1, 40);

		// mixer, tape sound from the adc input
		tape_ctrl.motor = 1'b0;
		tape_ctrl.use_adc = 1'b1;
		for (int i = 0; i < n_mix; i++) begin
			r = n_tape + 2 + REC_W * i;
			exp.left = vec[r + 7][15:0];
			exp.right = vec[r + 8][15:0];
			run_mix_case($sformatf("mix vector %0d", i), vec[r][1:0], vec[r + 1][1:0],
				vec[r + 2][0], vec[r + 3][11:0], vec[r + 4][11:0], vec[r + 5][11:0],
				vec[r + 6][13:0], exp);
		end
		for (int i = 0; i < N_RANDOM; i++) begin
			m = 2'($urandom);
			v = 2'($urandom);
			voices.a = 12'($urandom);
			voices.b = 12'($urandom);
			voices.c = 12'($urandom);
			voices.mix = 14'($urandom);
			adc_prev = 1'($urandom);
			exp = mix_rule(m, v, adc_prev, voices.a, voices.b, voices.c, voices.mix);
			run_mix_case($sformatf("mix random %0d", i), m, v, adc_prev, voices.a, voices.b,
				voices.c, voices.mix, exp);
		end

		// DAC density over a full window
		for (int i = 0; i < n_dac; i++) begin
			r = n_tape + 3 + REC_W * (n_mix + i);
			exp.left = vec[r + 7][15:0];
			exp.right = vec[r + 8][15:0];
			run_mix_case($sformatf("dac sample %0d", i), vec[r][1:0], vec[r + 1][1:0],
				vec[r + 2][0], vec[r + 3][11:0], vec[r + 4][11:0], vec[r + 5][11:0],
				vec[r + 6][13:0], exp);
			count_dac_ones($sformatf("dac %0d", i), exp);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule
